// ==== include/eth_traffic_csr_macros.svh ====
`ifndef ETH_TRAFFIC_CSR_MACROS_SVH
`define ETH_TRAFFIC_CSR_MACROS_SVH

// ----------------------------------------------------------
// CSR space geometry
// ----------------------------------------------------------
`define ETH_CSR_NUM_REG       13
// Byte address to 64-bit register index
`define ETH_CSR_ADDR_SHIFT    3

// Register indices, 3 to 5 are reserved and read zero
`define ETH_CSR_IDX_DFH       0
`define ETH_CSR_IDX_ID_L      1
`define ETH_CSR_IDX_ID_H      2
`define ETH_CSR_IDX_INIT      6
`define ETH_CSR_IDX_CMD       7
`define ETH_CSR_IDX_DATA      8
`define ETH_CSR_IDX_PORT      9
`define ETH_CSR_IDX_SCRATCH   10
`define ETH_CSR_IDX_SWAP      11
`define ETH_CSR_IDX_LINK      12

// ----------------------------------------------------------
// Per-bit write masks, set bits are RW
// ----------------------------------------------------------
`define ETH_CSR_WMASK_INIT    64'h0000_0000_0000_0001
// Command in 1:0, Avalon address in 47:32
`define ETH_CSR_WMASK_CMD     64'h0000_ffff_0000_0003
// Write data in the upper half, read data below is hardware owned
`define ETH_CSR_WMASK_DATA    64'hffff_ffff_0000_0000
`define ETH_CSR_WMASK_PORT    64'h0000_0000_0000_000f
`define ETH_CSR_WMASK_SCRATCH 64'hffff_ffff_ffff_ffff
`define ETH_CSR_WMASK_SWAP    64'h0000_0000_0000_0001

// Feature type 1, major version 1, end of list
`define ETH_CSR_DFH_VALUE     64'h1100_0100_0000_0000
`define ETH_CSR_AFU_ID_H      64'h823c_334c_98bf_11ea
`define ETH_CSR_AFU_ID_L      64'hbb37_0242_ac13_0002
// "E2E" then version 11
`define ETH_CSR_SCRATCH_RESET 64'h0000_0000_4532_4511

`endif

// ==== design/eth_traffic_csr_pkg.sv ====
`include "eth_traffic_csr_macros.svh"

package eth_traffic_csr_pkg;

   // ----------------------------------------------------------
   // Host CSR side
   // ----------------------------------------------------------
   // Byte address from the host
   typedef logic [15:0] csr_addr_t;

   // One CSR word
   typedef logic [63:0] csr_data_t;

   // Register number after the byte shift
   typedef logic [3:0] csr_index_t;

   // One-hot write strobes, one per register
   typedef logic [`ETH_CSR_NUM_REG-1:0] csr_strobe_t;

   // Whole register file as seen by the read mux
   typedef csr_data_t [`ETH_CSR_NUM_REG-1:0] csr_array_t;

   // ----------------------------------------------------------
   // Avalon-MM side toward the traffic controller
   // ----------------------------------------------------------
   typedef logic [15:0] avmm_addr_t;
   typedef logic [31:0] avmm_data_t;

   // Bit 0 requests a read, bit 1 a write
   typedef logic [1:0] mbox_cmd_t;

   // ----------------------------------------------------------
   // Datapath control outputs
   // ----------------------------------------------------------
   typedef logic [3:0] port_sel_t;
   typedef logic [31:0] link_status_t;

   // Mailbox master FSM
   typedef enum logic [1:0] {
      IDLE,
      REQ,
      DONE
   } mbox_state_e;

endpackage

// ==== design/eth_mailbox_if.sv ====
interface eth_mailbox_if;
   import eth_traffic_csr_pkg::*;

   // Command, address and write data from the CMD and DATA registers
   mbox_cmd_t  cmd;
   avmm_addr_t addr;
   avmm_data_t wdata;

   // Result of the finished transfer
   avmm_data_t rdata;
   // High from acceptance until cmd goes back to zero
   logic       ack;

   // Register file side
   modport regs (
      output cmd,
      output addr,
      output wdata,
      input  rdata,
      input  ack
   );

   // Avalon master side
   modport mbox (
      input  cmd,
      input  addr,
      input  wdata,
      output rdata,
      output ack
   );

endinterface

// ==== design/eth_csr_decode.sv ====
`include "eth_traffic_csr_macros.svh"

module eth_csr_decode (
   input  logic                             i_csr_wr,
   input  eth_traffic_csr_pkg::csr_addr_t   i_csr_addr,
   input  eth_traffic_csr_pkg::csr_array_t  i_regs,
   output eth_traffic_csr_pkg::csr_strobe_t o_wr_strobe,
   output eth_traffic_csr_pkg::csr_data_t   o_rd_data
);
   import eth_traffic_csr_pkg::*;

   // Full register number, low byte-offset bits dropped
   logic [$bits(csr_addr_t)-`ETH_CSR_ADDR_SHIFT-1:0] reg_num;
   csr_index_t                                      reg_idx;
   logic                                            in_range;

   // ----------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------
   assign reg_num = i_csr_addr[$bits(csr_addr_t)-1:`ETH_CSR_ADDR_SHIFT];

   // Compare on the full number so high address bits cannot alias
   assign in_range = (reg_num < `ETH_CSR_NUM_REG);

   // Only meaningful while in_range is set
   assign reg_idx = reg_num[$bits(csr_index_t)-1:0];

   // ----------------------------------------------------------
   // Write strobes
   // ----------------------------------------------------------
   // At most one strobe, none for addresses past the last register
   always_comb begin
      for (int i = 0; i < `ETH_CSR_NUM_REG; i++) begin
         o_wr_strobe[i] = i_csr_wr && in_range && (reg_idx == csr_index_t'(i));
      end
   end

   // ----------------------------------------------------------
   // Read mux
   // ----------------------------------------------------------
   // Same-cycle read, out of range reads zero
   always_comb begin
      if (in_range) begin
         o_rd_data = i_regs[reg_idx];
      end else begin
         o_rd_data = '0;
      end
   end

endmodule

// ==== design/eth_csr_regfile.sv ====
`include "eth_traffic_csr_macros.svh"

module eth_csr_regfile (
   input  logic                               clk,
   input  logic                               i_rst,
   input  eth_traffic_csr_pkg::csr_strobe_t   i_wr_strobe,
   input  eth_traffic_csr_pkg::csr_data_t     i_wr_data,
   input  eth_traffic_csr_pkg::link_status_t  i_link_status,
   eth_mailbox_if.regs                        mbox,
   output eth_traffic_csr_pkg::csr_array_t    o_regs,
   output eth_traffic_csr_pkg::port_sel_t     o_port_sel,
   output logic                               o_port_swap_en
);
   import eth_traffic_csr_pkg::*;

   csr_array_t regs_q;

   // ----------------------------------------------------------
   // Register attributes
   // ----------------------------------------------------------
   // RW bits per register, identity and reserved words get none
   function automatic csr_data_t reg_wmask(input int idx);
      case (idx)
         `ETH_CSR_IDX_INIT:    return `ETH_CSR_WMASK_INIT;
         `ETH_CSR_IDX_CMD:     return `ETH_CSR_WMASK_CMD;
         `ETH_CSR_IDX_DATA:    return `ETH_CSR_WMASK_DATA;
         `ETH_CSR_IDX_PORT:    return `ETH_CSR_WMASK_PORT;
         `ETH_CSR_IDX_SCRATCH: return `ETH_CSR_WMASK_SCRATCH;
         `ETH_CSR_IDX_SWAP:    return `ETH_CSR_WMASK_SWAP;
         default:              return '0;
      endcase
   endfunction

   // Reset value per register
   function automatic csr_data_t reg_reset(input int idx);
      case (idx)
         `ETH_CSR_IDX_DFH:     return `ETH_CSR_DFH_VALUE;
         `ETH_CSR_IDX_ID_L:    return `ETH_CSR_AFU_ID_L;
         `ETH_CSR_IDX_ID_H:    return `ETH_CSR_AFU_ID_H;
         `ETH_CSR_IDX_SCRATCH: return `ETH_CSR_SCRATCH_RESET;
         default:              return '0;
      endcase
   endfunction

   // RW bits take the new data, all others keep their value
   function automatic csr_data_t masked_write(
      input csr_data_t cur,
      input csr_data_t wdata,
      input csr_data_t mask
   );
      return (cur & ~mask) | (wdata & mask);
   endfunction

   // ----------------------------------------------------------
   // Register array
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_rst) begin
         for (int i = 0; i < `ETH_CSR_NUM_REG; i++) begin
            regs_q[i] <= reg_reset(i);
         end
      end else begin
         // Host writes, a zero mask leaves identity words untouched
         for (int i = 0; i < `ETH_CSR_NUM_REG; i++) begin
            if (i_wr_strobe[i]) begin
               regs_q[i] <= masked_write(regs_q[i], i_wr_data, reg_wmask(i));
            end
         end

         // Hardware fields, refreshed every cycle
         // These bits sit outside the write masks so there is no conflict
         regs_q[`ETH_CSR_IDX_CMD][2]     <= mbox.ack;
         regs_q[`ETH_CSR_IDX_DATA][31:0] <= mbox.rdata;
         // One cycle of sampling delay on link status
         regs_q[`ETH_CSR_IDX_LINK][31:0] <= i_link_status;
      end
   end

   assign o_regs = regs_q;

   // ----------------------------------------------------------
   // Field breakout
   // ----------------------------------------------------------
   // Datapath controls straight from the stored bits
   assign o_port_sel     = regs_q[`ETH_CSR_IDX_PORT][$bits(port_sel_t)-1:0];
   assign o_port_swap_en = regs_q[`ETH_CSR_IDX_SWAP][0];

   // Mailbox request fields
   assign mbox.cmd   = regs_q[`ETH_CSR_IDX_CMD][$bits(mbox_cmd_t)-1:0];
   assign mbox.addr  = regs_q[`ETH_CSR_IDX_CMD][47:32];
   assign mbox.wdata = regs_q[`ETH_CSR_IDX_DATA][63:32];

endmodule

// ==== design/eth_avmm_mailbox.sv ====
module eth_avmm_mailbox (
   input  logic                            clk,
   input  logic                            i_rst,
   eth_mailbox_if.mbox                     mbox,
   output eth_traffic_csr_pkg::avmm_addr_t o_avmm_addr,
   output logic                            o_avmm_read,
   output logic                            o_avmm_write,
   output eth_traffic_csr_pkg::avmm_data_t o_avmm_writedata,
   input  eth_traffic_csr_pkg::avmm_data_t i_avmm_readdata,
   input  logic                            i_avmm_waitrequest
);
   import eth_traffic_csr_pkg::*;

   mbox_state_e state_q;
   mbox_state_e state_d;
   avmm_addr_t  addr_q;
   avmm_data_t  wdata_q;
   avmm_data_t  rdata_q;
   logic        wr_q;
   logic        accept;

   // ----------------------------------------------------------
   // FSM
   // ----------------------------------------------------------
   // Slave takes the request in the first REQ cycle without waitrequest
   assign accept = (state_q == REQ) && !i_avmm_waitrequest;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (mbox.cmd != '0) begin
               state_d = REQ;
            end
         end
         REQ: begin
            if (!i_avmm_waitrequest) begin
               state_d = DONE;
            end
         end
         // Hold ack until software clears the command
         DONE: begin
            if (mbox.cmd == '0) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q <= IDLE;
         rdata_q <= '0;
      end else begin
         state_q <= state_d;
         if (accept && !wr_q) begin
            rdata_q <= i_avmm_readdata;
         end
      end
   end

   // Latch the request so it stays stable through waitrequest
   always_ff @(posedge clk) begin
      if ((state_q == IDLE) && (mbox.cmd != '0)) begin
         addr_q  <= mbox.addr;
         wdata_q <= mbox.wdata;
         // Write wins when both bits are set
         wr_q    <= mbox.cmd[1];
      end
   end

   // ----------------------------------------------------------
   // Outputs
   // ----------------------------------------------------------
   assign o_avmm_addr      = addr_q;
   assign o_avmm_writedata = wdata_q;
   assign o_avmm_read      = (state_q == REQ) && !wr_q;
   assign o_avmm_write     = (state_q == REQ) && wr_q;

   // Ack and read data are presented in the accept cycle itself
   // so the CMD and DATA registers hold them one cycle later
   assign mbox.ack   = (state_q == DONE) || accept;
   assign mbox.rdata = (accept && !wr_q) ? i_avmm_readdata : rdata_q;

endmodule

// ==== design/eth_traffic_csr.sv ====
module eth_traffic_csr (
   input  logic                              clk,
   input  logic                              i_rst,

   // Host CSR access, reads are combinational
   input  logic                              i_csr_wr,
   input  eth_traffic_csr_pkg::csr_addr_t    i_csr_addr,
   input  eth_traffic_csr_pkg::csr_data_t    i_csr_wr_data,
   output eth_traffic_csr_pkg::csr_data_t    o_csr_rd_data,

   // Avalon-MM master toward the traffic controller
   output eth_traffic_csr_pkg::avmm_addr_t   o_avmm_addr,
   output logic                              o_avmm_read,
   output logic                              o_avmm_write,
   output eth_traffic_csr_pkg::avmm_data_t   o_avmm_writedata,
   input  eth_traffic_csr_pkg::avmm_data_t   i_avmm_readdata,
   input  logic                              i_avmm_waitrequest,

   // Status in, datapath controls out
   input  eth_traffic_csr_pkg::link_status_t i_link_status,
   output eth_traffic_csr_pkg::port_sel_t    o_csr_port_sel,
   output logic                              o_port_swap_en
);
   import eth_traffic_csr_pkg::*;

   csr_strobe_t wr_strobe;
   csr_array_t  regs;

   // Command and result between register file and mailbox
   eth_mailbox_if mbox_if ();

   // ----------------------------------------------------------
   // Host side decode
   // ----------------------------------------------------------
   eth_csr_decode decode_i (
      .i_csr_wr    (i_csr_wr),
      .i_csr_addr  (i_csr_addr),
      .i_regs      (regs),
      .o_wr_strobe (wr_strobe),
      .o_rd_data   (o_csr_rd_data)
   );

   // ----------------------------------------------------------
   // Register storage
   // ----------------------------------------------------------
   eth_csr_regfile regfile_i (
      .clk            (clk),
      .i_rst          (i_rst),
      .i_wr_strobe    (wr_strobe),
      .i_wr_data      (i_csr_wr_data),
      .i_link_status  (i_link_status),
      .mbox           (mbox_if.regs),
      .o_regs         (regs),
      .o_port_sel     (o_csr_port_sel),
      .o_port_swap_en (o_port_swap_en)
   );

   // ----------------------------------------------------------
   // Avalon-MM mailbox master
   // ----------------------------------------------------------
   eth_avmm_mailbox mailbox_i (
      .clk                (clk),
      .i_rst              (i_rst),
      .mbox               (mbox_if.mbox),
      .o_avmm_addr        (o_avmm_addr),
      .o_avmm_read        (o_avmm_read),
      .o_avmm_write       (o_avmm_write),
      .o_avmm_writedata   (o_avmm_writedata),
      .i_avmm_readdata    (i_avmm_readdata),
      .i_avmm_waitrequest (i_avmm_waitrequest)
   );

endmodule

// ==== sim/eth_traffic_csr_tb.sv ====
`include "eth_traffic_csr_macros.svh"

module eth_traffic_csr_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import eth_traffic_csr_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int NUM_RANDOM = 300;
   // Random accesses plus reset sweep, link and mailbox steps
   localparam int NUM_OPS    = NUM_RANDOM + 120;
   localparam int MAX_STALL  = 8;
   localparam int SHIFT      = `ETH_CSR_ADDR_SHIFT;

   logic         clk;
   logic         i_rst;
   logic         i_csr_wr;
   csr_addr_t    i_csr_addr;
   csr_data_t    i_csr_wr_data;
   csr_data_t    o_csr_rd_data;
   avmm_addr_t   o_avmm_addr;
   logic         o_avmm_read;
   logic         o_avmm_write;
   avmm_data_t   o_avmm_writedata;
   avmm_data_t   i_avmm_readdata;
   logic         i_avmm_waitrequest;
   link_status_t i_link_status;
   port_sel_t    o_csr_port_sel;
   logic         o_port_swap_en;

   // Register model, indices 13 to 15 stay zero
   csr_data_t  model_regs [16];
   // Avalon slave memory and transfer log
   avmm_data_t slave_mem [avmm_addr_t];
   int         wr_count;
   int         rd_count;
   int         stall_cnt;
   avmm_addr_t last_wr_addr;
   avmm_data_t last_wr_data;

   eth_traffic_csr dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ----------------------------------------------------------
   // Reference values from the register map
   // ----------------------------------------------------------
   function automatic csr_data_t expected_mask(input int idx);
      case (idx)
         `ETH_CSR_IDX_INIT:    return `ETH_CSR_WMASK_INIT;
         `ETH_CSR_IDX_CMD:     return `ETH_CSR_WMASK_CMD;
         `ETH_CSR_IDX_DATA:    return `ETH_CSR_WMASK_DATA;
         `ETH_CSR_IDX_PORT:    return `ETH_CSR_WMASK_PORT;
         `ETH_CSR_IDX_SCRATCH: return `ETH_CSR_WMASK_SCRATCH;
         `ETH_CSR_IDX_SWAP:    return `ETH_CSR_WMASK_SWAP;
         default:              return '0;
      endcase
   endfunction

   function automatic csr_data_t reset_value(input int idx);
      case (idx)
         `ETH_CSR_IDX_DFH:     return `ETH_CSR_DFH_VALUE;
         `ETH_CSR_IDX_ID_L:    return `ETH_CSR_AFU_ID_L;
         `ETH_CSR_IDX_ID_H:    return `ETH_CSR_AFU_ID_H;
         `ETH_CSR_IDX_SCRATCH: return `ETH_CSR_SCRATCH_RESET;
         default:              return '0;
      endcase
   endfunction

   function automatic csr_data_t model_read(input csr_addr_t addr);
      int idx;
      idx = int'(addr >> SHIFT);
      if (idx < `ETH_CSR_NUM_REG) return model_regs[idx];
      return '0;
   endfunction

   // Unwritten words follow a pattern over the full address
   function automatic avmm_data_t slave_word(input avmm_addr_t addr);
      if (slave_mem.exists(addr)) return slave_mem[addr];
      return {addr ^ 16'hc3a5, ~addr};
   endfunction

   function automatic csr_addr_t random_addr();
      if ($urandom % 8 == 0) return csr_addr_t'($urandom);
      return csr_addr_t'($urandom_range(0, 16 * 8 - 1));
   endfunction

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------
   task automatic stop_on_error();
      $display("Test FAILED");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic fail_with_text(input string msg);
      $display("%s", msg);
      stop_on_error();
   endtask

   task automatic check_csr(input string name, input csr_data_t exp, input csr_data_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_avmm_addr(input string name, input avmm_addr_t exp,
                                  input avmm_addr_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_avmm_data(input string name, input avmm_data_t exp,
                                  input avmm_data_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_port(input string name, input port_sel_t exp, input port_sel_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: expected %b, actual %b", name, exp, act);
         stop_on_error();
      end
   endtask

   // ----------------------------------------------------------
   // Host access
   // ----------------------------------------------------------
   // One-cycle write, model updated through the mask
   task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
      int idx;
      idx = int'(addr >> SHIFT);
      @(posedge clk);
      #1;
      i_csr_wr      = 1'b1;
      i_csr_addr    = addr;
      i_csr_wr_data = data;
      @(posedge clk);
      #1;
      i_csr_wr = 1'b0;
      if (idx < `ETH_CSR_NUM_REG) begin
         model_regs[idx] = (model_regs[idx] & ~expected_mask(idx)) | (data & expected_mask(idx));
      end
   endtask

   // Combinational read, sampled 1 ns after the address settles
   task automatic csr_read_check(input csr_addr_t addr, input string name);
      @(posedge clk);
      #1;
      i_csr_addr = addr;
      #1;
      check_csr(name, model_read(addr), o_csr_rd_data);
   endtask

   // Poll CMD until the ack bit reaches the given level
   task automatic wait_ack(input logic level);
      do begin
         @(posedge clk);
         #1;
         i_csr_addr = `ETH_CSR_IDX_CMD << SHIFT;
         #1;
      end while (o_csr_rd_data[2] !== level);
      model_regs[`ETH_CSR_IDX_CMD][2] = level;
   endtask

   task automatic mailbox_write(input avmm_addr_t addr, input avmm_data_t data);
      int wr_before;
      wr_before = wr_count;
      csr_write(`ETH_CSR_IDX_DATA << SHIFT, {data, 32'h0});
      csr_write(`ETH_CSR_IDX_CMD << SHIFT, {16'h0, addr, 32'h0});
      csr_write(`ETH_CSR_IDX_CMD << SHIFT, {16'h0, addr, 32'h2});
      wait_ack(1'b1);
      if (wr_count != wr_before + 1) fail_with_text("Slave did not see exactly one mailbox write");
      check_avmm_addr("mailbox write address", addr, last_wr_addr);
      check_avmm_data("mailbox write data", data, last_wr_data);
      csr_read_check(`ETH_CSR_IDX_CMD << SHIFT, "cmd with write ack");
      // Clearing the command drops ack
      csr_write(`ETH_CSR_IDX_CMD << SHIFT, {16'h0, addr, 32'h0});
      wait_ack(1'b0);
      if (wr_count != wr_before + 1) fail_with_text("Mailbox write was repeated after ack");
      csr_read_check(`ETH_CSR_IDX_CMD << SHIFT, "cmd after write clear");
   endtask

   task automatic mailbox_read(input avmm_addr_t addr);
      int rd_before;
      rd_before = rd_count;
      csr_write(`ETH_CSR_IDX_CMD << SHIFT, {16'h0, addr, 32'h0});
      csr_write(`ETH_CSR_IDX_CMD << SHIFT, {16'h0, addr, 32'h1});
      wait_ack(1'b1);
      if (rd_count != rd_before + 1) fail_with_text("Slave did not see exactly one mailbox read");
      model_regs[`ETH_CSR_IDX_DATA][31:0] = slave_word(addr);
      csr_read_check(`ETH_CSR_IDX_DATA << SHIFT, "mailbox read data");
      check_flag("avmm read after ack", 1'b0, o_avmm_read);
      check_flag("avmm write after ack", 1'b0, o_avmm_write);
      csr_write(`ETH_CSR_IDX_CMD << SHIFT, {16'h0, addr, 32'h0});
      wait_ack(1'b0);
      if (rd_count != rd_before + 1) fail_with_text("Mailbox read was repeated after ack");
   endtask

   // ----------------------------------------------------------
   // Avalon-MM slave model
   // ----------------------------------------------------------
   // Transfer taken at the edge where waitrequest is low
   always @(posedge clk) begin
      if ((o_avmm_read || o_avmm_write) && !i_avmm_waitrequest) begin
         if (o_avmm_write) begin
            wr_count++;
            last_wr_addr          = o_avmm_addr;
            last_wr_data          = o_avmm_writedata;
            slave_mem[o_avmm_addr] = o_avmm_writedata;
         end else begin
            rd_count++;
         end
      end
      #1;
      // Random stall, never longer than MAX_STALL cycles
      if ((o_avmm_read || o_avmm_write) && stall_cnt < MAX_STALL && ($urandom % 2)) begin
         i_avmm_waitrequest = 1'b1;
         stall_cnt++;
      end else begin
         i_avmm_waitrequest = (o_avmm_read || o_avmm_write) ? 1'b0 : 1'($urandom % 2);
         stall_cnt          = 0;
      end
      i_avmm_readdata = slave_word(o_avmm_addr);
   end

   // Watchdog
   initial begin
      #(NUM_OPS * 20 * CLK_PERIOD);
      $display("Timeout, the DUT stopped responding before the tests finished");
      $display("Test FAILED");
      $fatal(1, "Watchdog expired");
   end

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial begin
      csr_addr_t  addr;
      csr_data_t  data;
      avmm_addr_t mb_addr;
      void'($urandom(32'h3fd5_680f));
      i_rst              = 1'b1;
      i_csr_wr           = 1'b0;
      i_csr_addr         = '0;
      i_csr_wr_data      = '0;
      i_avmm_readdata    = '0;
      i_avmm_waitrequest = 1'b0;
      i_link_status      = '0;
      wr_count           = 0;
      rd_count           = 0;
      stall_cnt          = 0;
      for (int i = 0; i < 16; i++) model_regs[i] = reset_value(i);
      repeat (4) @(posedge clk);
      #1;
      i_rst = 1'b0;

      // Reset values, out-of-range indices included
      for (int i = 0; i < 16; i++) csr_read_check(csr_addr_t'(i << SHIFT), "reset value");
      check_port("port_sel after reset", '0, o_csr_port_sel);
      check_flag("port_swap after reset", 1'b0, o_port_swap_en);

      // Random accesses, CMD written with the command bits clear
      for (int n = 0; n < NUM_RANDOM; n++) begin
         addr = random_addr();
         if ($urandom % 2) begin
            data = {$urandom, $urandom};
            if ((addr >> SHIFT) == `ETH_CSR_IDX_CMD) data[1:0] = 2'b00;
            csr_write(addr, data);
            check_port("port_sel", port_sel_t'(model_regs[`ETH_CSR_IDX_PORT]), o_csr_port_sel);
            check_flag("port_swap", model_regs[`ETH_CSR_IDX_SWAP][0], o_port_swap_en);
         end else begin
            csr_read_check(addr, "random read");
         end
      end
      for (int i = 0; i < 16; i++) csr_read_check(csr_addr_t'(i << SHIFT), "sweep after random");

      // Link status, read one cycle after it is driven
      for (int n = 0; n < 8; n++) begin
         @(posedge clk);
         #1;
         i_link_status = $urandom;
         i_csr_addr    = `ETH_CSR_IDX_LINK << SHIFT;
         #1;
         // New value stays hidden until the next edge
         check_csr("link status before sample", model_regs[`ETH_CSR_IDX_LINK], o_csr_rd_data);
         model_regs[`ETH_CSR_IDX_LINK] = {32'h0, i_link_status};
         csr_read_check(`ETH_CSR_IDX_LINK << SHIFT, "link status");
      end

      // Mailbox write, then read it back and a few random words
      mb_addr = avmm_addr_t'($urandom);
      mailbox_write(mb_addr, avmm_data_t'($urandom));
      mailbox_read(mb_addr);
      for (int n = 0; n < 4; n++) mailbox_read(avmm_addr_t'($urandom));

      $display("Test OK");
      $finish;
   end

endmodule

// ==== eth_traffic_csr.f ====
+incdir+include
design/eth_traffic_csr_pkg.sv
design/eth_mailbox_if.sv
design/eth_csr_decode.sv
design/eth_csr_regfile.sv
design/eth_avmm_mailbox.sv
design/eth_traffic_csr.sv
sim/eth_traffic_csr_tb.sv

// ==== Bender.yml ====
package:
  name: eth_traffic_csr

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/eth_traffic_csr_pkg.sv
      - design/eth_mailbox_if.sv
      - design/eth_csr_decode.sv
      - design/eth_csr_regfile.sv
      - design/eth_avmm_mailbox.sv
      - design/eth_traffic_csr.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/eth_traffic_csr_tb.sv
